// ==== logic/memBridge_cfg.svh ====
`ifndef MEM_BRIDGE_CFG_SVH
`define MEM_BRIDGE_CFG_SVH

// byte address width on both address channels
`define MB_ADDR_W 32

// array depth in 64-bit words
`define MB_DEPTH_WORDS 256

// word index width into the array
`define MB_INDEX_W ($clog2(`MB_DEPTH_WORDS))

`endif

// ==== logic/memBridgePkg.sv ====
`default_nettype none

`include "memBridge_cfg.svh"

package memBridgePkg;

  // one incrementing burst command
  typedef struct packed {
    logic [`MB_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
  } burstCmd_t;

  // write data channel payload
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
  } writeBeat_t;

  // read data channel payload
  typedef struct packed {
    logic [63:0] data;
    logic        last;
  } readBeat_t;

  // bytes per beat, sizes above 8 bytes still move 8
  function automatic logic [3:0] beatStep(input logic [2:0] size);
    logic [2:0] clipped;
    clipped = (size > 3'd3) ? 3'd3 : size;
    return 4'd1 << clipped;
  endfunction

endpackage

`default_nettype wire

// ==== logic/burstSequencer.sv ====
`default_nettype none

`include "memBridge_cfg.svh"

module burstSequencer (
  input  wire logic                    clock,
  input  wire logic                    reset,
  input  wire logic                    cmdValid,
  input  wire memBridgePkg::burstCmd_t cmd,
  input  wire logic                    advance,
  output logic                         cmdReady,
  output logic                         beatActive,
  output logic                         beatLast,
  output logic [2:0]                   beatSize,
  output logic [`MB_ADDR_W-1:0]        beatAddr
);
  import memBridgePkg::*;

  localparam logic Idle = 1'b0;
  localparam logic Active = 1'b1;

  logic                  state;
  logic [7:0]            countReg;
  logic [2:0]            sizeReg;
  logic [`MB_ADDR_W-1:0] addrReg;
  logic                  accept;
  logic                  step;

  assign cmdReady = (state == Idle);
  assign accept = cmdValid && cmdReady;
  assign beatActive = (state == Active);
  assign beatLast = beatActive && (countReg == 8'd0);
  assign step = advance && beatActive;

  assign beatAddr = addrReg;
  assign beatSize = sizeReg;

  // idle/active and remaining beats
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= Idle;
      countReg <= 8'd0;
    end else if (accept) begin
      state <= Active;
      countReg <= cmd.len;
    end else if (step) begin
      if (beatLast) begin
        state <= Idle;
      end else begin
        countReg <= countReg - 8'd1;
      end
    end
  end

  // burst payload
  always_ff @(posedge clock) begin
    if (accept) begin
      addrReg <= cmd.addr;
      sizeReg <= cmd.size;
    end else if (step) begin
      addrReg <= addrReg + `MB_ADDR_W'(beatStep(sizeReg));
    end
  end

  // advance comes from outside the sequencer and must only hit a live burst
  advanceWhileActive: assert property (
    @(posedge clock) disable iff (reset)
    advance |-> beatActive
  );

  // count only falls while the burst runs, and the zero beat ends it
  countNoWrap: assert property (
    @(posedge clock) disable iff (reset)
    step |=> !beatActive || (countReg < $past(countReg))
  );

endmodule

`default_nettype wire

// ==== logic/sramArray.sv ====
`default_nettype none

`include "memBridge_cfg.svh"

module sramArray (
  input  wire logic                     clock,
  input  wire logic                     readEnable,
  input  wire logic [`MB_INDEX_W-1:0]   readIndex,
  input  wire logic                     writeEnable,
  input  wire logic [`MB_INDEX_W-1:0]   writeIndex,
  input  wire memBridgePkg::writeBeat_t writeBeat,
  output logic [63:0]                   readWord
);

  logic [63:0] mem [`MB_DEPTH_WORDS];

  // registered read, holds its word while readEnable is low
  // same-word write in this cycle lands after the read samples
  always_ff @(posedge clock) begin
    if (readEnable) begin
      readWord <= mem[readIndex];
    end
  end

  // byte lanes follow the strobes as given
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      for (int lane = 0; lane < 8; lane++) begin
        if (writeBeat.strb[lane]) begin
          mem[writeIndex][lane*8 +: 8] <= writeBeat.data[lane*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/readResponder.sv ====
`default_nettype none

`include "memBridge_cfg.svh"

module readResponder (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   beatActive,
  input  wire logic                   beatLast,
  input  wire logic [`MB_ADDR_W-1:0]  beatAddr,
  input  wire logic [2:0]             size,
  input  wire logic [63:0]            readWord,
  input  wire logic                   rReady,
  output logic                        advance,
  output logic                        readEnable,
  output logic [`MB_INDEX_W-1:0]      readIndex,
  output logic                        rValid,
  output memBridgePkg::readBeat_t     rBeat
);
  import memBridgePkg::*;

  logic        slotFree;
  logic        issue;
  logic        pending;
  logic        lastIssued;
  logic        lastTaken;
  logic        pendLast;
  logic [2:0]  pendOffset;
  logic [2:0]  pendSize;
  logic [63:0] shiftedWord;
  logic [63:0] laneWord;
  readBeat_t   nextBeat;

  // output slot empty or handed over this cycle
  assign slotFree = !rValid || rReady;

  // a pending word always drains when the slot frees, so it never blocks an issue
  assign issue = beatActive && slotFree && !lastIssued;
  assign lastTaken = rValid && rReady && rBeat.last;

  // final beat retires the burst only once the data channel takes it
  assign advance = (issue && !beatLast) || lastTaken;

  assign readEnable = issue;
  assign readIndex = `MB_INDEX_W'((beatAddr >> 3) % `MB_DEPTH_WORDS);

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
      lastIssued <= 1'b0;
      rValid <= 1'b0;
    end else begin
      if (issue) begin
        pending <= 1'b1;
      end else if (slotFree) begin
        pending <= 1'b0;
      end
      if (issue && beatLast) begin
        lastIssued <= 1'b1;
      end else if (lastTaken) begin
        lastIssued <= 1'b0;
      end
      if (pending && slotFree) begin
        rValid <= 1'b1;
      end else if (slotFree) begin
        rValid <= 1'b0;
      end
    end
  end

  // lane info travels alongside the array read
  always_ff @(posedge clock) begin
    if (issue) begin
      pendOffset <= beatAddr[2:0];
      pendSize <= size;
      pendLast <= beatLast;
    end
  end

  // narrow beats land at bit 0, zero above
  assign shiftedWord = readWord >> {pendOffset, 3'b000};

  always_comb begin
    case (pendSize)
      3'd0: laneWord = {56'd0, shiftedWord[7:0]};
      3'd1: laneWord = {48'd0, shiftedWord[15:0]};
      3'd2: laneWord = {32'd0, shiftedWord[31:0]};
      default: laneWord = readWord;
    endcase
  end

  assign nextBeat = '{data: laneWord, last: pendLast};

  always_ff @(posedge clock) begin
    if (pending && slotFree) begin
      rBeat <= nextBeat;
    end
  end

  // a stalled beat keeps its value until the sink takes it
  rBeatHold: assert property (
    @(posedge clock) disable iff (reset)
    (rValid && !rReady) |=> (rValid && $stable(rBeat))
  );

endmodule

`default_nettype wire

// ==== logic/memBridge.sv ====
`default_nettype none

`include "memBridge_cfg.svh"

module memBridge (
  input  wire logic                     clock,
  input  wire logic                     reset,
  // read address channel
  input  wire logic                     arValid,
  output logic                          arReady,
  input  wire memBridgePkg::burstCmd_t  arCmd,
  // read data channel
  output logic                          rValid,
  input  wire logic                     rReady,
  output memBridgePkg::readBeat_t       rBeat,
  // write address channel
  input  wire logic                     awValid,
  output logic                          awReady,
  input  wire memBridgePkg::burstCmd_t  awCmd,
  // write data channel
  input  wire logic                     wValid,
  output logic                          wReady,
  input  wire memBridgePkg::writeBeat_t wBeat
);

  logic                  readAdvance;
  logic                  readActive;
  logic                  readLast;
  logic [2:0]            readSize;
  logic [`MB_ADDR_W-1:0] readAddr;
  logic                  readEnable;
  logic [`MB_INDEX_W-1:0] readIndex;
  logic [63:0]           readWord;
  logic                  writeFire;
  logic [`MB_ADDR_W-1:0] writeAddr;
  logic [`MB_INDEX_W-1:0] writeIndex;

  burstSequencer readSequencer (
    .clock      (clock),
    .reset      (reset),
    .cmdValid   (arValid),
    .cmd        (arCmd),
    .advance    (readAdvance),
    .cmdReady   (arReady),
    .beatActive (readActive),
    .beatLast   (readLast),
    .beatSize   (readSize),
    .beatAddr   (readAddr)
  );

  // write beats go straight to the array on the handshake
  assign writeFire = wValid && wReady;
  assign writeIndex = `MB_INDEX_W'((writeAddr >> 3) % `MB_DEPTH_WORDS);

  burstSequencer writeSequencer (
    .clock      (clock),
    .reset      (reset),
    .cmdValid   (awValid),
    .cmd        (awCmd),
    .advance    (writeFire),
    .cmdReady   (awReady),
    .beatActive (wReady),
    .beatLast   (),
    .beatSize   (),
    .beatAddr   (writeAddr)
  );

  sramArray array (
    .clock       (clock),
    .readEnable  (readEnable),
    .readIndex   (readIndex),
    .writeEnable (writeFire),
    .writeIndex  (writeIndex),
    .writeBeat   (wBeat),
    .readWord    (readWord)
  );

  readResponder responder (
    .clock      (clock),
    .reset      (reset),
    .beatActive (readActive),
    .beatLast   (readLast),
    .beatAddr   (readAddr),
    .size       (readSize),
    .readWord   (readWord),
    .rReady     (rReady),
    .advance    (readAdvance),
    .readEnable (readEnable),
    .readIndex  (readIndex),
    .rValid     (rValid),
    .rBeat      (rBeat)
  );

endmodule

`default_nettype wire

// ==== tests/memBridgeChecker.sv ====
`default_nettype none

`include "memBridge_cfg.svh"

module memBridgeChecker (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire logic                     arValid,
  input  wire logic                     arReady,
  input  wire memBridgePkg::burstCmd_t  arCmd,
  input  wire logic                     rValid,
  input  wire logic                     rReady,
  input  wire memBridgePkg::readBeat_t  rBeat,
  input  wire logic                     awValid,
  input  wire logic                     awReady,
  input  wire memBridgePkg::burstCmd_t  awCmd,
  input  wire logic                     wValid,
  input  wire logic                     wReady,
  input  wire memBridgePkg::writeBeat_t wBeat,
  output int                            errorCount
);
  timeunit 1ns;
  timeprecision 100ps;
  import memBridgePkg::*;

  // byte image of the array
  logic [7:0]  model [`MB_DEPTH_WORDS*8];
  burstCmd_t   rdCmd;
  burstCmd_t   wrCmd;
  logic        rdBusy;
  logic        wrBusy;
  logic        afterReset;
  logic        arReadyDue;
  logic        holding;
  readBeat_t   heldBeat;
  logic [63:0] want;

  initial errorCount = 0;

  function automatic int wordBase(input logic [`MB_ADDR_W-1:0] addr);
    return ((addr >> 3) % `MB_DEPTH_WORDS) * 8;
  endfunction

  // narrow beats start at the byte offset, wide beats take the whole word
  function automatic logic [63:0] predictData(input burstCmd_t cmd);
    logic [63:0] word;
    int          first;
    word = '0;
    first = (cmd.size > 3'd2) ? 0 : cmd.addr[2:0];
    for (int i = 0; i < beatStep(cmd.size); i++) begin
      if (first + i < 8) begin
        word[i*8 +: 8] = model[wordBase(cmd.addr) + first + i];
      end
    end
    return word;
  endfunction

  task automatic reportMismatch(input string name, input logic [65:0] expected,
                                input logic [65:0] actual);
    $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    errorCount++;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      rdBusy = 1'b0;
      wrBusy = 1'b0;
      holding = 1'b0;
      arReadyDue = 1'b0;
      afterReset = 1'b1;
    end else begin
      if (afterReset && ({arReady, awReady, rValid, wReady} !== 4'b1100)) begin
        reportMismatch("{arReady,awReady,rValid,wReady}", 4'b1100,
                       {arReady, awReady, rValid, wReady});
      end
      afterReset = 1'b0;
      if (arReadyDue && arReady !== 1'b1) begin
        reportMismatch("arReady", 1'b1, arReady);
      end
      arReadyDue = 1'b0;
      // no beat shows outside a read burst
      if (!rdBusy && rValid !== 1'b0) begin
        reportMismatch("rValid", 1'b0, rValid);
      end
      // write data side is open exactly while a write burst runs
      if ({awReady, wReady} !== {!wrBusy, wrBusy}) begin
        reportMismatch("{awReady,wReady}", {!wrBusy, wrBusy}, {awReady, wReady});
      end
      // stalled beat comes back unchanged
      if (holding && {rValid, rBeat} !== {1'b1, heldBeat}) begin
        reportMismatch("{rValid,rBeat}", {1'b1, heldBeat}, {rValid, rBeat});
      end
      holding = rValid && !rReady;
      heldBeat = rBeat;
      if (wValid && wReady && wrBusy) begin
        for (int lane = 0; lane < 8; lane++) begin
          if (wBeat.strb[lane]) begin
            model[wordBase(wrCmd.addr) + lane] = wBeat.data[lane*8 +: 8];
          end
        end
        wrCmd.addr += beatStep(wrCmd.size);
        wrBusy = (wrCmd.len != 8'd0);
        wrCmd.len -= 8'd1;
      end
      if (rValid && rReady && rdBusy) begin
        want = predictData(rdCmd);
        if (rBeat.data !== want) begin
          reportMismatch("rBeat.data", want, rBeat.data);
        end
        if (rBeat.last !== (rdCmd.len == 8'd0)) begin
          reportMismatch("rBeat.last", rdCmd.len == 8'd0, rBeat.last);
        end
        rdBusy = (rdCmd.len != 8'd0);
        arReadyDue = !rdBusy;
        rdCmd.addr += beatStep(rdCmd.size);
        rdCmd.len -= 8'd1;
      end
      if (arValid && arReady) begin
        rdCmd = arCmd;
        rdBusy = 1'b1;
      end
      if (awValid && awReady) begin
        wrCmd = awCmd;
        wrBusy = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/memBridgeTb.sv ====
`default_nettype none

`include "memBridge_cfg.svh"

module memBridgeTb;
  timeunit 1ns;
  timeprecision 100ps;
  import memBridgePkg::*;

  localparam int ClockPeriod = 40;
  localparam int ResetCycles = 10;
  localparam int NumOps = 14;

  typedef struct packed {
    logic                  isWrite;
    logic [`MB_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [7:0]            strb;
    logic                  stall;
  } opRow_t;

  logic       clock;
  logic       reset;
  logic       arValid;
  logic       arReady;
  burstCmd_t  arCmd;
  logic       rValid;
  logic       rReady;
  readBeat_t  rBeat;
  logic       awValid;
  logic       awReady;
  burstCmd_t  awCmd;
  logic       wValid;
  logic       wReady;
  writeBeat_t wBeat;
  int         errorCount;
  int         totalBeats;
  integer     seed;
  opRow_t     ops [NumOps];

  memBridge memBridge_inst (.*);

  memBridgeChecker beatChecker (.*);

  always #(ClockPeriod / 2) clock = ~clock;

  function automatic opRow_t makeRow(input logic isWrite, input logic [`MB_ADDR_W-1:0] addr,
                                     input logic [7:0] len, input logic [2:0] size,
                                     input logic [7:0] strb, input logic stall);
    return {isWrite, addr, len, size, strb, stall};
  endfunction

  task automatic runWrite(input opRow_t row);
    logic [31:0] hi;
    logic [31:0] lo;
    awCmd.addr = row.addr;
    awCmd.len = row.len;
    awCmd.size = row.size;
    awValid = 1'b1;
    #1;
    while (!awReady) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    awValid = 1'b0;
    for (int beat = 0; beat <= row.len; beat++) begin
      hi = $random(seed);
      lo = $random(seed);
      wBeat.data = {hi, lo};
      wBeat.strb = row.strb;
      wValid = 1'b1;
      #1;
      while (!wReady) begin
        @(negedge clock);
        #1;
      end
      @(negedge clock);
    end
    wValid = 1'b0;
  endtask

  task automatic runRead(input opRow_t row);
    logic        done;
    logic [31:0] roll;
    done = 1'b0;
    arCmd.addr = row.addr;
    arCmd.len = row.len;
    arCmd.size = row.size;
    arValid = 1'b1;
    #1;
    while (!arReady) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    arValid = 1'b0;
    // keep taking beats until the last one is handed over
    while (!done) begin
      roll = $random(seed);
      rReady = row.stall ? roll[0] : 1'b1;
      #1;
      done = rValid && rReady && rBeat.last;
      @(negedge clock);
    end
    rReady = 1'b0;
  endtask

  initial begin
    int beats;
    seed = 32'ha3075d67;
    clock = 1'b0;
    reset = 1'b1;
    arValid = 1'b0;
    arCmd = '0;
    rReady = 1'b0;
    awValid = 1'b0;
    awCmd = '0;
    wValid = 1'b0;
    wBeat = '0;
    // kind, address, len, size, strobes, random rReady
    ops[0] = makeRow(1'b1, 32'h100, 8'd3, 3'd3, 8'hFF, 1'b0);
    ops[1] = makeRow(1'b0, 32'h100, 8'd3, 3'd3, 8'h00, 1'b0);
    ops[2] = makeRow(1'b0, 32'h100, 8'd7, 3'd0, 8'h00, 1'b0);
    ops[3] = makeRow(1'b0, 32'h108, 8'd3, 3'd1, 8'h00, 1'b0);
    ops[4] = makeRow(1'b0, 32'h110, 8'd1, 3'd2, 8'h00, 1'b0);
    ops[5] = makeRow(1'b1, 32'h100, 8'd1, 3'd3, 8'h5A, 1'b0);
    ops[6] = makeRow(1'b0, 32'h100, 8'd3, 3'd3, 8'h00, 1'b1);
    ops[7] = makeRow(1'b1, 32'h200, 8'd15, 3'd3, 8'hFF, 1'b0);
    ops[8] = makeRow(1'b0, 32'h200, 8'd31, 3'd2, 8'h00, 1'b1);
    ops[9] = makeRow(1'b1, 32'h120, 8'd1, 3'd3, 8'hFF, 1'b0);
    ops[10] = makeRow(1'b1, 32'h120, 8'd3, 3'd2, 8'hF0, 1'b0);
    ops[11] = makeRow(1'b0, 32'h120, 8'd3, 3'd2, 8'h00, 1'b1);
    ops[12] = makeRow(1'b0, 32'h200, 8'd2, 3'd4, 8'h00, 1'b1);
    ops[13] = makeRow(1'b0, 32'h101, 8'd5, 3'd0, 8'h00, 1'b1);
    beats = 0;
    for (int i = 0; i < NumOps; i++) begin
      beats += ops[i].len + 1;
    end
    totalBeats = beats;
    repeat (ResetCycles) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    for (int i = 0; i < NumOps; i++) begin
      if (ops[i].isWrite) begin
        runWrite(ops[i]);
      end else begin
        runRead(ops[i]);
      end
    end
    repeat (4) @(negedge clock);
    $display("memBridgeTb done, error count %0d", errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // 8 cycles per beat plus slack for commands and reset
  initial begin
    wait (totalBeats > 0);
    #((totalBeats * 8 + 200) * ClockPeriod);
    $display("timeout: the DUT stopped handing over beats before the table finished");
    $display("memBridgeTb done, error count %0d", errorCount);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== memBridge.f ====
+incdir+logic
logic/memBridgePkg.sv
logic/burstSequencer.sv
logic/sramArray.sv
logic/readResponder.sv
logic/memBridge.sv
tests/memBridgeChecker.sv
tests/memBridgeTb.sv
